// File: fill_rect_pkg.sv
package fill_rect_pkg;

    // 16-bit coordinate or size, used for origin, extent and clip
    typedef logic [15:0] coord_t;

    // 4:4:4 colour, red in the top nibble
    typedef logic [11:0] rgb_t;

    // x, y, w, h as big-endian pairs, then r, g, b
    localparam int CMD_BYTES = 11;

    // config register map
    localparam logic [1:0] REG_FB_BASE = 2'd0;
    localparam logic [1:0] REG_STRIDE  = 2'd1;
    // clip width in [31:16], clip height in [15:0]
    localparam logic [1:0] REG_CLIP    = 2'd2;
    // completed rectangles, read only
    localparam logic [1:0] REG_COUNT   = 2'd3;

endpackage

// File: cmd_fifo.sv
`timescale 1ns/10ps

module cmd_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic       clk,
    input  logic       rst_,
    input  logic       wr_valid,
    input  logic [7:0] wr_data,
    output logic       wr_ready,
    output logic       cmd_fifo_rts,
    output logic [7:0] cmd_fifo_data,
    input  logic       cmd_fifo_rtr
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [7:0]     mem [FIFO_DEPTH];
    // extra msb tells full from empty
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;
    logic           full;
    logic           push;
    logic           pop;

    assign full = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                  (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    assign wr_ready      = !full;
    assign cmd_fifo_rts  = (wr_ptr != rd_ptr);
    assign cmd_fifo_data = mem[rd_ptr[PTR_W-1:0]];

    assign push = wr_valid && wr_ready;
    assign pop  = cmd_fifo_rts && cmd_fifo_rtr;

    always_ff @(posedge clk or negedge rst_)
    begin
        if (!rst_)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr[PTR_W-1:0]] <= wr_data;
    end

    // read side never runs past the write side, occupancy stays within depth
    a_no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_)
        (PTR_W+1)'(wr_ptr - rd_ptr) <= FIFO_DEPTH);

endmodule

// File: fill_rect_decode_engine.sv
`timescale 1ns/10ps

module fill_rect_decode_engine (
    input  logic                 clk,
    input  logic                 rst_,
    input  logic                 data_gen_is_idle,
    output logic                 dec_eng_has_data,
    output logic                 cmd_fifo_rtr,
    input  logic                 cmd_fifo_rts,
    input  logic [7:0]           cmd_fifo_data,
    output fill_rect_pkg::coord_t cmd_data_origx,
    output fill_rect_pkg::coord_t cmd_data_origy,
    output fill_rect_pkg::coord_t cmd_data_wid,
    output fill_rect_pkg::coord_t cmd_data_hgt,
    output fill_rect_pkg::rgb_t   cmd_data_rgb,
    output logic                 addr_start_strobe
);

    import fill_rect_pkg::*;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_ORIGX_HI,
        ST_ORIGX_LO,
        ST_ORIGY_HI,
        ST_ORIGY_LO,
        ST_WID_HI,
        ST_WID_LO,
        ST_HGT_HI,
        ST_HGT_LO,
        ST_R,
        ST_G,
        ST_B
    } dec_state_t;

    dec_state_t dec_state;
    logic       pop;
    logic [3:0] rval;
    logic [3:0] gval;
    // bytes taken so far in the current command
    logic [3:0] byte_cnt;

    assign cmd_fifo_rtr      = (dec_state != ST_IDLE);
    assign pop               = cmd_fifo_rtr && cmd_fifo_rts;
    assign dec_eng_has_data  = (dec_state == ST_G) || (dec_state == ST_B);
    assign addr_start_strobe = (dec_state == ST_B) && cmd_fifo_rts;

    // blue comes straight from the FIFO so the generator sees it on the strobe edge
    assign cmd_data_rgb = {rval, gval, cmd_fifo_data[3:0]};

    always_ff @(posedge clk or negedge rst_)
    begin
        if (!rst_)
        begin
            dec_state <= ST_IDLE;
            byte_cnt  <= '0;
        end
        else
        begin
            if (dec_state == ST_IDLE)
            begin
                byte_cnt <= '0;
                // hold off while a rectangle is still being drawn
                if (cmd_fifo_rts && data_gen_is_idle)
                    dec_state <= ST_ORIGX_HI;
            end
            else if (pop)
            begin
                byte_cnt <= byte_cnt + 4'd1;
                if (dec_state == ST_B)
                    dec_state <= ST_IDLE;
                else
                    dec_state <= dec_state_t'(dec_state + 4'd1);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            case (dec_state)
                ST_ORIGX_HI: cmd_data_origx[15:8] <= cmd_fifo_data;
                ST_ORIGX_LO: cmd_data_origx[7:0]  <= cmd_fifo_data;
                ST_ORIGY_HI: cmd_data_origy[15:8] <= cmd_fifo_data;
                ST_ORIGY_LO: cmd_data_origy[7:0]  <= cmd_fifo_data;
                ST_WID_HI:   cmd_data_wid[15:8]   <= cmd_fifo_data;
                ST_WID_LO:   cmd_data_wid[7:0]    <= cmd_fifo_data;
                ST_HGT_HI:   cmd_data_hgt[15:8]   <= cmd_fifo_data;
                ST_HGT_LO:   cmd_data_hgt[7:0]    <= cmd_fifo_data;
                // colour keeps the low nibble only
                ST_R:        rval                 <= cmd_fifo_data[3:0];
                ST_G:        gval                 <= cmd_fifo_data[3:0];
                default:     ;
            endcase
        end
    end

    // strobe only on the last byte of a full command
    a_strobe_on_last_byte: assert property (@(posedge clk) disable iff (!rst_)
        addr_start_strobe |-> dec_state == ST_B && byte_cnt == 4'(CMD_BYTES - 1));

    // bytes are taken only while no rectangle is being drawn
    a_read_while_gen_idle: assert property (@(posedge clk) disable iff (!rst_)
        cmd_fifo_rtr |-> data_gen_is_idle);

endmodule

// File: fill_rect_pixel_gen.sv
`timescale 1ns/10ps

module fill_rect_pixel_gen #(
    parameter int ADDR_W = 24
) (
    input  logic                  clk,
    input  logic                  rst_,
    input  logic                  addr_start_strobe,
    input  fill_rect_pkg::coord_t cmd_data_origx,
    input  fill_rect_pkg::coord_t cmd_data_origy,
    input  fill_rect_pkg::coord_t cmd_data_wid,
    input  fill_rect_pkg::coord_t cmd_data_hgt,
    input  fill_rect_pkg::rgb_t   cmd_data_rgb,
    input  logic [ADDR_W-1:0]     fb_base,
    input  fill_rect_pkg::coord_t stride,
    input  fill_rect_pkg::coord_t clip_w,
    input  fill_rect_pkg::coord_t clip_h,
    output logic                  data_gen_is_idle,
    output logic                  rect_done,
    output logic                  pix_valid,
    input  logic                  pix_ready,
    output logic [ADDR_W-1:0]     pix_addr,
    output fill_rect_pkg::rgb_t   pix_rgb
);

    import fill_rect_pkg::*;

    logic              active;
    coord_t            col;
    coord_t            row;
    coord_t            origx_q;
    coord_t            origy_q;
    coord_t            wid_q;
    coord_t            hgt_q;
    coord_t            stride_q;
    coord_t            clip_w_q;
    coord_t            clip_h_q;
    rgb_t              rgb_q;
    logic [ADDR_W-1:0] row_addr;
    logic [31:0]       org_prod;
    logic [16:0]       pos_x;
    logic [16:0]       pos_y;
    logic              empty;
    logic              in_clip;
    logic              row_end;
    logic              last_pos;
    logic              advance;

    // one multiply per rectangle, later rows just add the stride
    assign org_prod = 32'(cmd_data_origy) * 32'(stride);

    assign empty    = (wid_q == '0) || (hgt_q == '0);
    assign pos_x    = {1'b0, origx_q} + {1'b0, col};
    assign pos_y    = {1'b0, origy_q} + {1'b0, row};
    assign in_clip  = (pos_x < {1'b0, clip_w_q}) && (pos_y < {1'b0, clip_h_q});
    assign row_end  = (col == wid_q - 16'd1);
    assign last_pos = empty || (row_end && row == hgt_q - 16'd1);

    assign pix_valid        = active && !empty && in_clip;
    // clipped positions step on without waiting for ready
    assign advance          = active && (!pix_valid || pix_ready);
    assign pix_addr         = row_addr + ADDR_W'(col);
    assign pix_rgb          = rgb_q;
    assign data_gen_is_idle = !active;

    always_ff @(posedge clk or negedge rst_)
    begin
        if (!rst_)
        begin
            active    <= 1'b0;
            rect_done <= 1'b0;
            col       <= '0;
            row       <= '0;
        end
        else
        begin
            rect_done <= 1'b0;
            if (addr_start_strobe)
            begin
                active <= 1'b1;
                col    <= '0;
                row    <= '0;
            end
            else if (advance)
            begin
                if (last_pos)
                begin
                    active    <= 1'b0;
                    rect_done <= 1'b1;
                end
                else if (row_end)
                begin
                    col <= '0;
                    row <= row + 16'd1;
                end
                else
                    col <= col + 16'd1;
            end
        end
    end

    // frame setup is captured at start so register writes hit the next rectangle
    always_ff @(posedge clk)
    begin
        if (addr_start_strobe)
        begin
            origx_q  <= cmd_data_origx;
            origy_q  <= cmd_data_origy;
            wid_q    <= cmd_data_wid;
            hgt_q    <= cmd_data_hgt;
            rgb_q    <= cmd_data_rgb;
            stride_q <= stride;
            clip_w_q <= clip_w;
            clip_h_q <= clip_h;
            row_addr <= fb_base + ADDR_W'(org_prod) + ADDR_W'(cmd_data_origx);
        end
        else if (advance && !last_pos && row_end)
            row_addr <= row_addr + ADDR_W'(stride_q);
    end

    // the decoder must wait for idle before starting the next command
    a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_)
        addr_start_strobe |-> !active);

    // a stalled pixel keeps its payload
    a_stall_stable: assert property (@(posedge clk) disable iff (!rst_)
        pix_valid && !pix_ready |=> pix_valid && $stable(pix_addr) && $stable(pix_rgb));

endmodule

// File: fb_config_regs.sv
`timescale 1ns/10ps

module fb_config_regs #(
    parameter int ADDR_W = 24
) (
    input  logic                  clk,
    input  logic                  rst_,
    input  logic                  cfg_wr,
    input  logic [1:0]            cfg_addr,
    input  logic [31:0]           cfg_wdata,
    output logic [31:0]           cfg_rdata,
    output logic [ADDR_W-1:0]     fb_base,
    output fill_rect_pkg::coord_t stride,
    output fill_rect_pkg::coord_t clip_w,
    output fill_rect_pkg::coord_t clip_h,
    input  logic                  rect_done,
    input  logic                  data_gen_is_idle,
    input  logic                  dec_eng_has_data,
    output logic                  busy
);

    import fill_rect_pkg::*;

    logic [31:0] done_count;

    always_ff @(posedge clk or negedge rst_)
    begin
        if (!rst_)
        begin
            fb_base    <= '0;
            stride     <= '0;
            clip_w     <= '0;
            clip_h     <= '0;
            done_count <= '0;
        end
        else
        begin
            if (cfg_wr)
            begin
                case (cfg_addr)
                    REG_FB_BASE: fb_base <= cfg_wdata[ADDR_W-1:0];
                    REG_STRIDE:  stride  <= cfg_wdata[15:0];
                    REG_CLIP:
                    begin
                        clip_w <= cfg_wdata[31:16];
                        clip_h <= cfg_wdata[15:0];
                    end
                    // count is read only
                    default:     ;
                endcase
            end
            if (rect_done)
                done_count <= done_count + 32'd1;
        end
    end

    always_comb
    begin
        case (cfg_addr)
            REG_FB_BASE: cfg_rdata = 32'(fb_base);
            REG_STRIDE:  cfg_rdata = {16'd0, stride};
            REG_CLIP:    cfg_rdata = {clip_w, clip_h};
            default:     cfg_rdata = done_count;
        endcase
    end

    // decoder holding colour bytes means a start is imminent
    assign busy = !data_gen_is_idle || dec_eng_has_data;

endmodule

// File: fill_rect_top.sv
`timescale 1ns/10ps

module fill_rect_top #(
    parameter int ADDR_W     = 24,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                clk,
    input  logic                rst_,
    input  logic                cmd_valid,
    input  logic [7:0]          cmd_data,
    output logic                cmd_ready,
    input  logic                cfg_wr,
    input  logic [1:0]          cfg_addr,
    input  logic [31:0]         cfg_wdata,
    output logic [31:0]         cfg_rdata,
    output logic                busy,
    output logic                pix_valid,
    input  logic                pix_ready,
    output logic [ADDR_W-1:0]   pix_addr,
    output fill_rect_pkg::rgb_t pix_rgb
);

    import fill_rect_pkg::*;

    logic              cmd_fifo_rts;
    logic              cmd_fifo_rtr;
    logic [7:0]        cmd_fifo_data;
    logic              data_gen_is_idle;
    logic              dec_eng_has_data;
    logic              addr_start_strobe;
    logic              rect_done;
    coord_t            cmd_data_origx;
    coord_t            cmd_data_origy;
    coord_t            cmd_data_wid;
    coord_t            cmd_data_hgt;
    rgb_t              cmd_data_rgb;
    logic [ADDR_W-1:0] fb_base;
    coord_t            stride;
    coord_t            clip_w;
    coord_t            clip_h;

    cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_cmd_fifo (
        .clk           (clk),
        .rst_          (rst_),
        .wr_valid      (cmd_valid),
        .wr_data       (cmd_data),
        .wr_ready      (cmd_ready),
        .cmd_fifo_rts  (cmd_fifo_rts),
        .cmd_fifo_data (cmd_fifo_data),
        .cmd_fifo_rtr  (cmd_fifo_rtr)
    );

    fill_rect_decode_engine u_decode (
        .clk               (clk),
        .rst_              (rst_),
        .data_gen_is_idle  (data_gen_is_idle),
        .dec_eng_has_data  (dec_eng_has_data),
        .cmd_fifo_rtr      (cmd_fifo_rtr),
        .cmd_fifo_rts      (cmd_fifo_rts),
        .cmd_fifo_data     (cmd_fifo_data),
        .cmd_data_origx    (cmd_data_origx),
        .cmd_data_origy    (cmd_data_origy),
        .cmd_data_wid      (cmd_data_wid),
        .cmd_data_hgt      (cmd_data_hgt),
        .cmd_data_rgb      (cmd_data_rgb),
        .addr_start_strobe (addr_start_strobe)
    );

    fill_rect_pixel_gen #(
        .ADDR_W (ADDR_W)
    ) u_pixel_gen (
        .clk               (clk),
        .rst_              (rst_),
        .addr_start_strobe (addr_start_strobe),
        .cmd_data_origx    (cmd_data_origx),
        .cmd_data_origy    (cmd_data_origy),
        .cmd_data_wid      (cmd_data_wid),
        .cmd_data_hgt      (cmd_data_hgt),
        .cmd_data_rgb      (cmd_data_rgb),
        .fb_base           (fb_base),
        .stride            (stride),
        .clip_w            (clip_w),
        .clip_h            (clip_h),
        .data_gen_is_idle  (data_gen_is_idle),
        .rect_done         (rect_done),
        .pix_valid         (pix_valid),
        .pix_ready         (pix_ready),
        .pix_addr          (pix_addr),
        .pix_rgb           (pix_rgb)
    );

    fb_config_regs #(
        .ADDR_W (ADDR_W)
    ) u_config_regs (
        .clk              (clk),
        .rst_             (rst_),
        .cfg_wr           (cfg_wr),
        .cfg_addr         (cfg_addr),
        .cfg_wdata        (cfg_wdata),
        .cfg_rdata        (cfg_rdata),
        .fb_base          (fb_base),
        .stride           (stride),
        .clip_w           (clip_w),
        .clip_h           (clip_h),
        .rect_done        (rect_done),
        .data_gen_is_idle (data_gen_is_idle),
        .dec_eng_has_data (dec_eng_has_data),
        .busy             (busy)
    );

endmodule

// File: tb_fill_rect.sv
`timescale 1ns/10ps

module tb_fill_rect;

    import fill_rect_pkg::*;

    localparam int ADDR_W    = 24;
    localparam int MAX_CASES = 32;

    logic              clk;
    logic              rst_;
    logic              cmd_valid;
    logic [7:0]        cmd_data;
    logic              cmd_ready;
    logic              cfg_wr;
    logic [1:0]        cfg_addr;
    logic [31:0]       cfg_wdata;
    logic [31:0]       cfg_rdata;
    logic              busy;
    logic              pix_valid;
    logic              pix_ready;
    logic [ADDR_W-1:0] pix_addr;
    rgb_t              pix_rgb;

    // one entry per data line, W uses arg 0 and 1, R uses x y w h r g b
    logic [7:0]        kind [MAX_CASES];
    logic [127:0]      name [MAX_CASES];
    logic [31:0]       arg [MAX_CASES][7];
    int                num_lines;
    int                num_rects;
    int                sent_rects;
    int                error_count;
    int                pix_errors;
    int                cycle_limit;
    int                cycle_cnt;
    int                seed_val;
    logic              limit_ready;

    // reference copy of the frame registers
    logic [ADDR_W-1:0] model_base;
    logic [15:0]       model_stride;
    logic [15:0]       model_clip_w;
    logic [15:0]       model_clip_h;

    logic [ADDR_W-1:0] exp_addr [$];
    rgb_t              exp_rgb [$];
    int                exp_case [$];

    fill_rect_top #(
        .ADDR_W     (ADDR_W),
        .FIFO_DEPTH (16)
    ) UUT (
        .clk       (clk),
        .rst_      (rst_),
        .cmd_valid (cmd_valid),
        .cmd_data  (cmd_data),
        .cmd_ready (cmd_ready),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .busy      (busy),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .pix_addr  (pix_addr),
        .pix_rgb   (pix_rgb)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic compare_value(input logic [127:0] case_name, input logic [31:0] expected,
                                 input logic [31:0] actual, inout int errors);
        if (expected !== actual)
        begin
            errors = errors + 1;
            $display("CHECK FAILED %0s: expected %h, actual %h", case_name, expected, actual);
        end
    endtask

    task automatic read_cases();
        int            fd;
        int            code;
        logic [7:0]    tag;
        logic [1023:0] rest;
        cycle_limit = 2000;
        fd = $fopen("fill_rect_cases.txt", "r");
        if (fd == 0)
        begin
            error_count = error_count + 1;
            $display("could not open fill_rect_cases.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                code = $fscanf(fd, "%s", tag);
                if (code == 1 && tag == "#")
                    code = $fgets(rest, fd);
                else if (code == 1 && tag == "W")
                begin
                    kind[num_lines] = tag;
                    name[num_lines] = 128'("cfg_write");
                    code = $fscanf(fd, "%d %h", arg[num_lines][0], arg[num_lines][1]);
                    num_lines++;
                end
                else if (code == 1 && tag == "R")
                begin
                    kind[num_lines] = tag;
                    code = $fscanf(fd, "%s %d %d %d %d %h %h %h", name[num_lines],
                                   arg[num_lines][0], arg[num_lines][1], arg[num_lines][2],
                                   arg[num_lines][3], arg[num_lines][4], arg[num_lines][5],
                                   arg[num_lines][6]);
                    // bytes plus every position, clipped or not
                    cycle_limit = cycle_limit +
                                  40 * (CMD_BYTES + arg[num_lines][2] * arg[num_lines][3]);
                    num_lines++;
                    num_rects++;
                end
            end
            $fclose(fd);
        end
        limit_ready = 1'b1;
    endtask

    // reference walk of one rectangle, row-major, clip then address
    task automatic queue_pixels(input int idx);
        int          row;
        int          col;
        logic [16:0] px;
        logic [16:0] py;
        logic [47:0] full_addr;
        for (row = 0; row < int'(arg[idx][3]); row++)
        begin
            for (col = 0; col < int'(arg[idx][2]); col++)
            begin
                px = 17'(arg[idx][0][15:0]) + 17'(col);
                py = 17'(arg[idx][1][15:0]) + 17'(row);
                if (px < 17'(model_clip_w) && py < 17'(model_clip_h))
                begin
                    full_addr = 48'(model_base) + 48'(py) * 48'(model_stride) + 48'(px);
                    exp_addr.push_back(full_addr[ADDR_W-1:0]);
                    exp_rgb.push_back({arg[idx][4][3:0], arg[idx][5][3:0], arg[idx][6][3:0]});
                    exp_case.push_back(idx);
                end
            end
        end
    endtask

    task automatic send_rect(input int idx);
        int         b;
        logic [7:0] cmd_bytes [CMD_BYTES];
        cmd_bytes[0]  = arg[idx][0][15:8];
        cmd_bytes[1]  = arg[idx][0][7:0];
        cmd_bytes[2]  = arg[idx][1][15:8];
        cmd_bytes[3]  = arg[idx][1][7:0];
        cmd_bytes[4]  = arg[idx][2][15:8];
        cmd_bytes[5]  = arg[idx][2][7:0];
        cmd_bytes[6]  = arg[idx][3][15:8];
        cmd_bytes[7]  = arg[idx][3][7:0];
        cmd_bytes[8]  = arg[idx][4][7:0];
        cmd_bytes[9]  = arg[idx][5][7:0];
        cmd_bytes[10] = arg[idx][6][7:0];
        cmd_valid = 1'b1;
        for (b = 0; b < CMD_BYTES; b++)
        begin
            cmd_data = cmd_bytes[b];
            // byte goes in on the next rising edge with ready high
            while (!cmd_ready)
                @(negedge clk);
            @(negedge clk);
        end
        cmd_valid = 1'b0;
        sent_rects++;
    endtask

    // wait until every sent rectangle has been counted as done
    task automatic wait_drained();
        cfg_addr = REG_COUNT;
        @(negedge clk);
        while (cfg_rdata < 32'(sent_rects))
            @(negedge clk);
    endtask

    task automatic write_reg(input int idx);
        logic [31:0] readback;
        cfg_wr    = 1'b1;
        cfg_addr  = arg[idx][0][1:0];
        cfg_wdata = arg[idx][1];
        @(negedge clk);
        cfg_wr = 1'b0;
        case (arg[idx][0][1:0])
            REG_FB_BASE:
            begin
                model_base = arg[idx][1][ADDR_W-1:0];
                readback   = 32'(model_base);
            end
            REG_STRIDE:
            begin
                model_stride = arg[idx][1][15:0];
                readback     = {16'd0, model_stride};
            end
            REG_CLIP:
            begin
                model_clip_w = arg[idx][1][31:16];
                model_clip_h = arg[idx][1][15:0];
                readback     = {model_clip_w, model_clip_h};
            end
            // count must not take the written value
            default: readback = 32'(sent_rects);
        endcase
        compare_value(name[idx], readback, cfg_rdata, error_count);
    endtask

    // random back-pressure and in-order pixel check
    initial
    begin
        seed_val   = $urandom(32'hc70edd46);
        pix_ready  = 1'b0;
        pix_errors = 0;
        forever
        begin
            @(negedge clk);
            pix_ready = ($urandom & 32'd3) != 32'd0;
            if (pix_valid && pix_ready)
            begin
                if (exp_addr.size() == 0)
                begin
                    pix_errors = pix_errors + 1;
                    $display("pixel at address %h arrived when none was expected", pix_addr);
                end
                else
                begin
                    compare_value(name[exp_case[0]], 32'(exp_addr[0]), 32'(pix_addr), pix_errors);
                    compare_value(name[exp_case[0]], 32'(exp_rgb[0]), 32'(pix_rgb), pix_errors);
                    exp_addr.delete(0);
                    exp_rgb.delete(0);
                    exp_case.delete(0);
                end
            end
        end
    end

    initial
    begin
        cycle_cnt = 0;
        wait (limit_ready);
        while (cycle_cnt < cycle_limit)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the run did not finish, %0d errors so far",
                 cycle_cnt, error_count + pix_errors);
        $display("Test FAILED");
        $finish;
    end

    initial
    begin
        rst_         = 1'b0;
        cmd_valid    = 1'b0;
        cmd_data     = 8'd0;
        cfg_wr       = 1'b0;
        cfg_addr     = 2'd0;
        cfg_wdata    = 32'd0;
        error_count  = 0;
        num_lines    = 0;
        num_rects    = 0;
        sent_rects   = 0;
        limit_ready  = 1'b0;
        model_base   = '0;
        model_stride = '0;
        model_clip_w = '0;
        model_clip_h = '0;
        read_cases();
        repeat (8) @(negedge clk);
        rst_ = 1'b1;
        for (int i = 0; i < num_lines; i++)
        begin
            // register changes only between rectangles
            if (kind[i] == "W")
            begin
                wait_drained();
                write_reg(i);
            end
            else
            begin
                queue_pixels(i);
                send_rect(i);
            end
        end
        wait_drained();
        if (exp_addr.size() != 0)
        begin
            error_count = error_count + 1;
            $display("%0d expected pixels never came out of the DUT", exp_addr.size());
        end
        compare_value(128'("final_count"), 32'(num_rects), cfg_rdata, error_count);
        compare_value(128'("final_busy"), 32'd0, 32'(busy), error_count);
        $display("run complete: %0d check errors, %0d pixel errors", error_count, pix_errors);
        if (error_count + pix_errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: filelist.f
fill_rect_pkg.sv
cmd_fifo.sv
fill_rect_decode_engine.sv
fill_rect_pixel_gen.sv
fb_config_regs.sv
fill_rect_top.sv
tb_fill_rect.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the fill_rect testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module tb_fill_rect \
    -o sim_fill_rect || { echo "build failed"; exit 1; }
sim_out=$(./obj_dir/sim_fill_rect)
echo "$sim_out"
echo "$sim_out" | grep -qx "Test OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: fill_rect_cases.txt
# W <reg index> <value, hex>
# R <name> <x> <y> <w> <h> <r> <g> <b>   coords decimal, colour bytes hex
W 2 00400030
W 1 00000100
W 0 00010000
R inside 4 3 5 4 0a 05 03
R clip_right 60 10 8 3 f0 1c 07
R clip_corner 62 46 4 4 01 02 03
R zero_width 10 10 0 5 04 04 04
R zero_height 10 10 5 0 05 05 05
R past_clip 70 50 3 3 06 06 06
R burst_a 0 0 6 2 0f 00 00
R burst_b 8 1 3 3 00 0f 00
R burst_c 1 20 7 1 00 00 0f
W 0 00200000
W 1 00000140
R new_base 2 2 3 3 0c 0d 0e
W 3 00000055
W 0 00ffff00
R wrap_around 30 40 4 2 09 08 07
